// File: source/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and register file widths
`define CPU_DATA_W        32
`define CPU_REG_ADDR_W    5

// word index widths of the two memories
`define CPU_IMEM_ADDR_W   9
`define CPU_DMEM_ADDR_W   10

// opcode field, instr[31:26]
`define CPU_OP_RTYPE      6'h00
`define CPU_OP_J          6'h02
`define CPU_OP_BEQ        6'h04
`define CPU_OP_ADDI       6'h08
`define CPU_OP_LW         6'h23
`define CPU_OP_SW         6'h2b

// function field of r-type, instr[5:0]
`define CPU_FN_ADD        6'h20
`define CPU_FN_SUB        6'h22
`define CPU_FN_AND        6'h24
`define CPU_FN_OR         6'h25
`define CPU_FN_SLT        6'h2a

`endif

// File: source/cpu_pkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package cpu_pkg;

   typedef enum logic [2:0] {
      alu_add = 3'd0,
      alu_sub = 3'd1,
      alu_and = 3'd2,
      alu_or  = 3'd3,
      alu_slt = 3'd4
   } alu_op_t;

   typedef struct packed {
      logic reg_write;
      logic mem_read;
      logic mem_write;
      logic mem_to_reg;
      logic alu_src;
      logic reg_dst;
   } ctrl_t;

   typedef struct packed {
      logic [`CPU_DATA_W-1:0] instr;
      logic [`CPU_DATA_W-1:0] pc_plus4;
   } if_id_t;

   // dest is already resolved from reg_dst in decode
   typedef struct packed {
      ctrl_t                     ctrl;
      alu_op_t                   alu_op;
      logic [`CPU_DATA_W-1:0]    rdata_1;
      logic [`CPU_DATA_W-1:0]    rdata_2;
      logic [`CPU_DATA_W-1:0]    imm;
      logic [`CPU_REG_ADDR_W-1:0] rs;
      logic [`CPU_REG_ADDR_W-1:0] rt;
      logic [`CPU_REG_ADDR_W-1:0] dest;
   } id_ex_t;

   typedef struct packed {
      ctrl_t                     ctrl;
      logic [`CPU_DATA_W-1:0]    alu_result;
      logic [`CPU_DATA_W-1:0]    store_data;
      logic [`CPU_REG_ADDR_W-1:0] dest;
   } ex_mem_t;

   typedef struct packed {
      logic                      reg_write;
      logic                      mem_to_reg;
      logic [`CPU_DATA_W-1:0]    load_data;
      logic [`CPU_DATA_W-1:0]    alu_result;
      logic [`CPU_REG_ADDR_W-1:0] dest;
   } mem_wb_t;

   typedef struct packed {
      logic                      wen;
      logic [`CPU_REG_ADDR_W-1:0] dest;
      logic [`CPU_DATA_W-1:0]    data;
   } wb_t;

   // host side access, addr is a word index
   typedef struct packed {
      logic [`CPU_DATA_W-1:0]    addr;
      logic                      wen;
      logic                      ren;
      logic [`CPU_DATA_W-1:0]    wdata;
   } host_req_t;

endpackage

`default_nettype wire

// File: source/sram.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module sram #(
   parameter int ADDR_W = 9
) (
   input  wire                          clk,
   input  wire  [ADDR_W-1:0]            addr,
   input  wire                          wen,
   input  wire  [`CPU_DATA_W-1:0]       wdata,
   output logic [`CPU_DATA_W-1:0]       rdata,
   input  wire  cpu_pkg::host_req_t     host,
   output logic [`CPU_DATA_W-1:0]       host_rdata
);

   logic [`CPU_DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
   logic [ADDR_W-1:0]      host_addr;

   assign host_addr = host.addr[ADDR_W-1:0];

   // pipeline side reads asynchronously
   assign rdata = mem[addr];

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[addr] <= wdata;
      end
      // host write comes last, so it wins on the same word
      if (host.wen) begin
         mem[host_addr] <= host.wdata;
      end
      if (host.ren) begin
         host_rdata <= mem[host_addr];
      end
   end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module fetch_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          enable,
   input  wire                          stall,
   input  wire                          redirect,
   input  wire  [`CPU_DATA_W-1:0]       redirect_pc,
   input  wire  cpu_pkg::host_req_t     imem_host,
   output logic [`CPU_DATA_W-1:0]       imem_host_rdata,
   output cpu_pkg::if_id_t              if_id
);

   logic [`CPU_DATA_W-1:0] pc;
   logic [`CPU_DATA_W-1:0] pc_plus4;
   logic [`CPU_DATA_W-1:0] instr;

   assign pc_plus4 = pc + `CPU_DATA_W'd4;

   sram #(
      .ADDR_W(`CPU_IMEM_ADDR_W)
   ) imem_inst (
      .clk       (clk),
      .addr      (pc[`CPU_IMEM_ADDR_W+1:2]),
      .wen       (1'b0),
      .wdata     ('0),
      .rdata     (instr),
      .host      (imem_host),
      .host_rdata(imem_host_rdata)
   );

   // always predict not taken, decode corrects with redirect
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (enable) begin
         if (redirect) begin
            pc <= redirect_pc;
         end else if (!stall) begin
            pc <= pc_plus4;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         if_id <= '0;
      end else if (enable) begin
         if (redirect) begin
            // squash the wrong-path fetch
            if_id <= '0;
         end else if (!stall) begin
            if_id.instr    <= instr;
            if_id.pc_plus4 <= pc_plus4;
         end
      end
   end

   assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else $error("fetch pc lost word alignment: %h", pc);

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module decode_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          enable,
   input  wire  cpu_pkg::if_id_t        if_id,
   input  wire  cpu_pkg::wb_t           wb,
   output logic                         stall,
   output logic                         redirect,
   output logic [`CPU_DATA_W-1:0]       redirect_pc,
   output cpu_pkg::id_ex_t              id_ex
);

   logic [5:0]                 opcode;
   logic [5:0]                 funct;
   logic [`CPU_REG_ADDR_W-1:0] rs;
   logic [`CPU_REG_ADDR_W-1:0] rt;
   logic [`CPU_REG_ADDR_W-1:0] rd;
   logic [`CPU_DATA_W-1:0]     imm_ext;
   logic [`CPU_DATA_W-1:0]     rdata_1;
   logic [`CPU_DATA_W-1:0]     rdata_2;
   logic [`CPU_DATA_W-1:0]     branch_target;
   logic [`CPU_DATA_W-1:0]     jump_target;
   logic                       is_beq;
   logic                       is_jump;
   cpu_pkg::ctrl_t             ctrl;
   cpu_pkg::alu_op_t           alu_op;
   logic [`CPU_DATA_W-1:0]     regs [0:(1<<`CPU_REG_ADDR_W)-1];

   assign opcode  = if_id.instr[31:26];
   assign rs      = if_id.instr[25:21];
   assign rt      = if_id.instr[20:16];
   assign rd      = if_id.instr[15:11];
   assign funct   = if_id.instr[5:0];
   assign imm_ext = {{(`CPU_DATA_W-16){if_id.instr[15]}}, if_id.instr[15:0]};

   // unknown opcodes and function codes decode to a nop
   always_comb begin
      ctrl    = '0;
      alu_op  = cpu_pkg::alu_add;
      is_beq  = 1'b0;
      is_jump = 1'b0;
      case (opcode)
         `CPU_OP_RTYPE: begin
            ctrl.reg_dst = 1'b1;
            ctrl.reg_write = 1'b1;
            case (funct)
               `CPU_FN_ADD: alu_op = cpu_pkg::alu_add;
               `CPU_FN_SUB: alu_op = cpu_pkg::alu_sub;
               `CPU_FN_AND: alu_op = cpu_pkg::alu_and;
               `CPU_FN_OR:  alu_op = cpu_pkg::alu_or;
               `CPU_FN_SLT: alu_op = cpu_pkg::alu_slt;
               default:     ctrl = '0;
            endcase
         end
         `CPU_OP_ADDI: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         `CPU_OP_LW: begin
            ctrl.reg_write  = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.alu_src    = 1'b1;
         end
         `CPU_OP_SW: begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         `CPU_OP_BEQ: is_beq = 1'b1;
         `CPU_OP_J:   is_jump = 1'b1;
         default: ;
      endcase
   end

   // register file, write first so wb is seen in the same cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < (1 << `CPU_REG_ADDR_W); i++) begin
            regs[i] <= '0;
         end
      end else if (enable && wb.wen && wb.dest != '0) begin
         regs[wb.dest] <= wb.data;
      end
   end

   assign rdata_1 = (rs == '0) ? '0 : (wb.wen && wb.dest == rs) ? wb.data : regs[rs];
   assign rdata_2 = (rt == '0) ? '0 : (wb.wen && wb.dest == rt) ? wb.data : regs[rt];

   // load in id/ex feeding this instruction
   assign stall = id_ex.ctrl.mem_read && id_ex.rt != '0 &&
                  (id_ex.rt == rs || id_ex.rt == rt);

   assign branch_target = if_id.pc_plus4 + {imm_ext[`CPU_DATA_W-3:0], 2'b00};
   assign jump_target   = {if_id.pc_plus4[`CPU_DATA_W-1:28], if_id.instr[25:0], 2'b00};

   // no forwarding into the compare, software keeps two slots of distance
   assign redirect    = !stall && (is_jump || (is_beq && rdata_1 == rdata_2));
   assign redirect_pc = is_jump ? jump_target : branch_target;

   always_ff @(posedge clk) begin
      if (reset) begin
         id_ex <= '0;
      end else if (enable) begin
         // bubble on stall
         id_ex.ctrl    <= stall ? '0 : ctrl;
         id_ex.alu_op  <= alu_op;
         id_ex.rdata_1 <= rdata_1;
         id_ex.rdata_2 <= rdata_2;
         id_ex.imm     <= imm_ext;
         id_ex.rs      <= rs;
         id_ex.rt      <= rt;
         id_ex.dest    <= ctrl.reg_dst ? rd : rt;
      end
   end

   assert property (@(posedge clk) disable iff (reset) !(redirect && stall))
      else $error("decode redirect raised during a load-use stall");

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module execute_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          enable,
   input  wire  cpu_pkg::id_ex_t        id_ex,
   input  wire  cpu_pkg::wb_t           wb,
   output cpu_pkg::ex_mem_t             ex_mem
);

   logic                   fwd_mem_a;
   logic                   fwd_mem_b;
   logic                   fwd_wb_a;
   logic                   fwd_wb_b;
   logic [`CPU_DATA_W-1:0] op_a;
   logic [`CPU_DATA_W-1:0] rt_val;
   logic [`CPU_DATA_W-1:0] op_b;
   logic [`CPU_DATA_W-1:0] alu_result;

   // ex/mem is the newer producer and takes priority
   assign fwd_mem_a = ex_mem.ctrl.reg_write && ex_mem.dest != '0 && ex_mem.dest == id_ex.rs;
   assign fwd_mem_b = ex_mem.ctrl.reg_write && ex_mem.dest != '0 && ex_mem.dest == id_ex.rt;
   assign fwd_wb_a  = wb.wen && wb.dest != '0 && wb.dest == id_ex.rs;
   assign fwd_wb_b  = wb.wen && wb.dest != '0 && wb.dest == id_ex.rt;

   assign op_a   = fwd_mem_a ? ex_mem.alu_result :
                   fwd_wb_a  ? wb.data : id_ex.rdata_1;
   assign rt_val = fwd_mem_b ? ex_mem.alu_result :
                   fwd_wb_b  ? wb.data : id_ex.rdata_2;
   assign op_b   = id_ex.ctrl.alu_src ? id_ex.imm : rt_val;

   always_comb begin
      case (id_ex.alu_op)
         cpu_pkg::alu_add: alu_result = op_a + op_b;
         cpu_pkg::alu_sub: alu_result = op_a - op_b;
         cpu_pkg::alu_and: alu_result = op_a & op_b;
         cpu_pkg::alu_or:  alu_result = op_a | op_b;
         cpu_pkg::alu_slt: alu_result = {{(`CPU_DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default:          alu_result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_mem <= '0;
      end else if (enable) begin
         ex_mem.ctrl       <= id_ex.ctrl;
         ex_mem.alu_result <= alu_result;
         // stores take the forwarded rt value
         ex_mem.store_data <= rt_val;
         ex_mem.dest       <= id_ex.dest;
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      id_ex.ctrl.reg_write |-> id_ex.alu_op inside {cpu_pkg::alu_add, cpu_pkg::alu_sub,
         cpu_pkg::alu_and, cpu_pkg::alu_or, cpu_pkg::alu_slt})
      else $error("illegal alu op %0d on a register writing instruction", id_ex.alu_op);

endmodule

`default_nettype wire

// File: source/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module memory_stage (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          enable,
   input  wire  cpu_pkg::ex_mem_t       ex_mem,
   input  wire  cpu_pkg::host_req_t     dmem_host,
   output logic [`CPU_DATA_W-1:0]       dmem_host_rdata,
   output cpu_pkg::wb_t                 wb
);

   logic [`CPU_DATA_W-1:0] load_data;
   cpu_pkg::mem_wb_t       mem_wb;

   // alu result is used directly as the word index
   sram #(
      .ADDR_W(`CPU_DMEM_ADDR_W)
   ) dmem_inst (
      .clk       (clk),
      .addr      (ex_mem.alu_result[`CPU_DMEM_ADDR_W-1:0]),
      .wen       (ex_mem.ctrl.mem_write && enable),
      .wdata     (ex_mem.store_data),
      .rdata     (load_data),
      .host      (dmem_host),
      .host_rdata(dmem_host_rdata)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_wb <= '0;
      end else if (enable) begin
         mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
         mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
         mem_wb.load_data  <= load_data;
         mem_wb.alu_result <= ex_mem.alu_result;
         mem_wb.dest       <= ex_mem.dest;
      end
   end

   // writeback select
   assign wb.wen  = mem_wb.reg_write;
   assign wb.dest = mem_wb.dest;
   assign wb.data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

   assert property (@(posedge clk) disable iff (reset)
      !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write))
      else $error("load and store both flagged in ex/mem");

endmodule

`default_nettype wire

// File: source/cpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          enable,
   input  wire  cpu_pkg::host_req_t     imem_host,
   output logic [`CPU_DATA_W-1:0]       imem_host_rdata,
   input  wire  cpu_pkg::host_req_t     dmem_host,
   output logic [`CPU_DATA_W-1:0]       dmem_host_rdata
);

   cpu_pkg::if_id_t        if_id;
   cpu_pkg::id_ex_t        id_ex;
   cpu_pkg::ex_mem_t       ex_mem;
   cpu_pkg::wb_t           wb;
   logic                   stall;
   logic                   redirect;
   logic [`CPU_DATA_W-1:0] redirect_pc;

   fetch_stage fetch_inst (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .stall          (stall),
      .redirect       (redirect),
      .redirect_pc    (redirect_pc),
      .imem_host      (imem_host),
      .imem_host_rdata(imem_host_rdata),
      .if_id          (if_id)
   );

   decode_stage decode_inst (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .if_id      (if_id),
      .wb         (wb),
      .stall      (stall),
      .redirect   (redirect),
      .redirect_pc(redirect_pc),
      .id_ex      (id_ex)
   );

   execute_stage execute_inst (
      .clk   (clk),
      .reset (reset),
      .enable(enable),
      .id_ex (id_ex),
      .wb    (wb),
      .ex_mem(ex_mem)
   );

   memory_stage memory_inst (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .ex_mem         (ex_mem),
      .dmem_host      (dmem_host),
      .dmem_host_rdata(dmem_host_rdata),
      .wb             (wb)
   );

endmodule

`default_nettype wire

// File: sim/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// runs one instruction at a time, no delay slots
// returns the step of the jump to itself, or -1 when it never halts
function automatic int execute_program(
   ref logic [`CPU_DATA_W-1:0] imem [0:(1<<`CPU_IMEM_ADDR_W)-1],
   ref logic [`CPU_DATA_W-1:0] dmem [0:(1<<`CPU_DMEM_ADDR_W)-1]
);
   logic [`CPU_DATA_W-1:0]     regs [0:(1<<`CPU_REG_ADDR_W)-1];
   logic [`CPU_DATA_W-1:0]     pc;
   logic [`CPU_DATA_W-1:0]     next_pc;
   logic [`CPU_DATA_W-1:0]     ins;
   logic [`CPU_DATA_W-1:0]     a;
   logic [`CPU_DATA_W-1:0]     b;
   logic [`CPU_DATA_W-1:0]     imm;
   logic [`CPU_DATA_W-1:0]     addr;
   logic [`CPU_DATA_W-1:0]     result;
   logic [`CPU_REG_ADDR_W-1:0] rt;
   logic [`CPU_REG_ADDR_W-1:0] rd;
   for (int i = 0; i < (1 << `CPU_REG_ADDR_W); i++) begin
      regs[i] = '0;
   end
   pc = '0;
   for (int step = 0; step < 4096; step++) begin
      ins     = imem[pc[`CPU_IMEM_ADDR_W+1:2]];
      a       = regs[ins[25:21]];
      b       = regs[ins[20:16]];
      rt      = ins[20:16];
      rd      = ins[15:11];
      imm     = {{(`CPU_DATA_W-16){ins[15]}}, ins[15:0]};
      addr    = a + imm;
      next_pc = pc + 4;
      case (ins[31:26])
         `CPU_OP_RTYPE: begin
            case (ins[5:0])
               `CPU_FN_ADD: result = a + b;
               `CPU_FN_SUB: result = a - b;
               `CPU_FN_AND: result = a & b;
               `CPU_FN_OR:  result = a | b;
               `CPU_FN_SLT: result = ($signed(a) < $signed(b)) ? 1 : 0;
               default:     rd = '0;
            endcase
            if (rd != '0) regs[rd] = result;
         end
         `CPU_OP_ADDI: if (rt != '0) regs[rt] = addr;
         `CPU_OP_LW:   if (rt != '0) regs[rt] = dmem[addr[`CPU_DMEM_ADDR_W-1:0]];
         `CPU_OP_SW:   dmem[addr[`CPU_DMEM_ADDR_W-1:0]] = b;
         `CPU_OP_BEQ:  if (a == b) next_pc = pc + 4 + {imm[`CPU_DATA_W-3:0], 2'b00};
         `CPU_OP_J: begin
            next_pc = {next_pc[`CPU_DATA_W-1:28], ins[25:0], 2'b00};
            if (next_pc == pc) return step;
         end
         default: ;
      endcase
      pc = next_pc;
   end
   return -1;
endfunction

`endif

// File: sim/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu_tb;

   localparam int DONE_ADDR   = 63;
   localparam int REGION_SIZE = 64;
   localparam int POLL_LIMIT  = 300;

   typedef struct packed {
      logic                   imem;
      logic [`CPU_DATA_W-1:0] addr;
      logic [`CPU_DATA_W-1:0] exp;
      logic [`CPU_DATA_W-1:0] got;
   } sample_t;

   logic                   clk;
   logic                   reset;
   logic                   enable;
   cpu_pkg::host_req_t     imem_host;
   cpu_pkg::host_req_t     dmem_host;
   logic [`CPU_DATA_W-1:0] imem_host_rdata;
   logic [`CPU_DATA_W-1:0] dmem_host_rdata;

   // mirrors of what the host loaded, and the model's data memory
   logic [`CPU_DATA_W-1:0] imem_img [0:(1<<`CPU_IMEM_ADDR_W)-1];
   logic [`CPU_DATA_W-1:0] dmem_img [0:(1<<`CPU_DMEM_ADDR_W)-1];
   logic [`CPU_DATA_W-1:0] ref_dmem [0:(1<<`CPU_DMEM_ADDR_W)-1];
   logic [`CPU_DATA_W-1:0] prog [$];
   sample_t                check_q [$];
   int                     checks;
   int                     errors;
   int                     timeouts;

   `include "cpu_ref_model.svh"

   cpu cpu_inst (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .imem_host      (imem_host),
      .imem_host_rdata(imem_host_rdata),
      .dmem_host      (dmem_host),
      .dmem_host_rdata(dmem_host_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] rtype_word(input logic [5:0] fn, input int rd, input int rs,
                                               input int rt);
      return {`CPU_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
   endfunction

   function automatic logic [31:0] itype_word(input logic [5:0] op, input int rt, input int rs,
                                               input int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [31:0] jtype_word(input int index);
      return {`CPU_OP_J, index[25:0]};
   endfunction

   task automatic write_word(input bit to_imem, input int addr, input logic [31:0] data);
      cpu_pkg::host_req_t req;
      req       = '0;
      req.addr  = addr;
      req.wen   = 1'b1;
      req.wdata = data;
      @(posedge clk);
      if (to_imem) imem_host <= req;
      else dmem_host <= req;
      @(posedge clk);
      imem_host <= '0;
      dmem_host <= '0;
   endtask

   // read data is registered, sample it half a cycle later
   task automatic read_word(input bit from_imem, input int addr, output logic [31:0] data);
      cpu_pkg::host_req_t req;
      req      = '0;
      req.addr = addr;
      req.ren  = 1'b1;
      @(posedge clk);
      if (from_imem) imem_host <= req;
      else dmem_host <= req;
      @(posedge clk);
      imem_host <= '0;
      dmem_host <= '0;
      @(negedge clk);
      data = from_imem ? imem_host_rdata : dmem_host_rdata;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset  <= 1'b1;
      enable <= 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic check_host_access();
      logic [31:0] iw [8];
      logic [31:0] dw [8];
      logic [31:0] word;
      for (int i = 0; i < 8; i++) begin
         iw[i] = $urandom;
         dw[i] = $urandom;
         write_word(1'b1, 256 + i, iw[i]);
         write_word(1'b0, 512 + i, dw[i]);
      end
      for (int i = 0; i < 8; i++) begin
         read_word(1'b1, 256 + i, word);
         check_q.push_back(sample_t'{1'b1, 256 + i, iw[i], word});
         read_word(1'b0, 512 + i, word);
         check_q.push_back(sample_t'{1'b0, 512 + i, dw[i], word});
      end
   endtask

   // 0 alu, 1 forwarding, 2 load-use, 3 control flow
   task automatic build_program(input int which);
      prog.delete();
      case (which)
         0: begin
            prog = '{itype_word(`CPU_OP_LW, 1, 0, 0), itype_word(`CPU_OP_LW, 2, 0, 1),
                     itype_word(`CPU_OP_LW, 10, 0, 2), rtype_word(`CPU_FN_ADD, 3, 1, 2),
                     rtype_word(`CPU_FN_SUB, 4, 1, 2), rtype_word(`CPU_FN_AND, 5, 1, 2),
                     rtype_word(`CPU_FN_OR, 6, 1, 2), rtype_word(`CPU_FN_SLT, 7, 1, 2),
                     rtype_word(`CPU_FN_SLT, 8, 2, 1), itype_word(`CPU_OP_ADDI, 9, 10, -100)};
            for (int r = 3; r <= 9; r++) prog.push_back(itype_word(`CPU_OP_SW, r, 0, 29 + r));
         end
         1: prog = '{itype_word(`CPU_OP_LW, 1, 0, 2), itype_word(`CPU_OP_LW, 2, 0, 3), 32'd0,
                     32'd0, rtype_word(`CPU_FN_ADD, 3, 1, 2), rtype_word(`CPU_FN_ADD, 4, 3, 3),
                     rtype_word(`CPU_FN_SUB, 5, 4, 3), rtype_word(`CPU_FN_OR, 6, 5, 4),
                     itype_word(`CPU_OP_SW, 6, 0, 40), itype_word(`CPU_OP_ADDI, 7, 6, 5),
                     rtype_word(`CPU_FN_AND, 8, 7, 6), itype_word(`CPU_OP_ADDI, 9, 0, 41),
                     itype_word(`CPU_OP_SW, 8, 9, 0), itype_word(`CPU_OP_SW, 7, 0, 42),
                     rtype_word(`CPU_FN_SLT, 12, 8, 7), itype_word(`CPU_OP_SW, 12, 0, 43)};
         2: prog = '{itype_word(`CPU_OP_LW, 1, 0, 4), rtype_word(`CPU_FN_ADD, 2, 1, 1),
                     itype_word(`CPU_OP_SW, 2, 0, 44), itype_word(`CPU_OP_LW, 3, 0, 5),
                     itype_word(`CPU_OP_SW, 3, 0, 45), itype_word(`CPU_OP_ADDI, 6, 0, 6),
                     itype_word(`CPU_OP_LW, 4, 6, 0), rtype_word(`CPU_FN_SUB, 5, 4, 1),
                     itype_word(`CPU_OP_SW, 5, 0, 46)};
         // taken beq skips words 48 and 49, j skips word 51
         default: prog = '{itype_word(`CPU_OP_ADDI, 1, 0, 5), itype_word(`CPU_OP_ADDI, 2, 0, 5),
                     itype_word(`CPU_OP_ADDI, 3, 0, 6), itype_word(`CPU_OP_ADDI, 4, 0, 11),
                     itype_word(`CPU_OP_BEQ, 2, 1, 2), itype_word(`CPU_OP_SW, 4, 0, 48),
                     itype_word(`CPU_OP_SW, 4, 0, 49), itype_word(`CPU_OP_BEQ, 3, 1, 1),
                     itype_word(`CPU_OP_SW, 3, 0, 50), jtype_word(11),
                     itype_word(`CPU_OP_SW, 4, 0, 51), itype_word(`CPU_OP_SW, 1, 0, 52)};
      endcase
      prog.push_back(itype_word(`CPU_OP_ADDI, 31, 0, 1));
      prog.push_back(itype_word(`CPU_OP_SW, 31, 0, DONE_ADDR));
      prog.push_back(jtype_word(prog.size()));
   endtask

   task automatic run_until_done(input bit freeze, output bit done);
      logic [31:0] word;
      int          hold;
      done = 1'b0;
      @(posedge clk);
      enable <= 1'b1;
      for (int polls = 0; polls < POLL_LIMIT && !done; polls++) begin
         if (freeze && $urandom % 3 == 0) begin
            hold = 1 + $urandom % 6;
            @(posedge clk);
            enable <= 1'b0;
            repeat (hold) @(posedge clk);
            enable <= 1'b1;
         end
         read_word(1'b0, DONE_ADDR, word);
         done = (word === 32'd1);
      end
      @(posedge clk);
      enable <= 1'b0;
   endtask

   task automatic run_case(input int which, input bit freeze);
      logic [31:0] word;
      int          steps;
      bit          done;
      apply_reset();
      build_program(which);
      for (int i = 0; i < prog.size() + 2; i++) begin
         imem_img[i] = (i < prog.size()) ? prog[i] : '0;
         write_word(1'b1, i, imem_img[i]);
      end
      for (int i = 0; i < REGION_SIZE; i++) begin
         dmem_img[i] = (i == DONE_ADDR) ? '0 : $urandom;
         write_word(1'b0, i, dmem_img[i]);
      end
      ref_dmem = dmem_img;
      steps = execute_program(imem_img, ref_dmem);
      assert (steps > 0) else begin
         errors++;
         $display("reference model of program %0d never reached its halt jump", which);
      end
      run_until_done(freeze, done);
      assert (done) else begin
         timeouts++;
         $display("program %0d did not set the completion word within %0d polls", which,
                  POLL_LIMIT);
      end
      for (int i = 0; i < REGION_SIZE; i++) begin
         read_word(1'b0, i, word);
         check_q.push_back(sample_t'{1'b0, i, ref_dmem[i], word});
      end
   endtask

   always @(posedge clk) begin : compare_results
      sample_t s;
      while (check_q.size() > 0) begin
         s = check_q.pop_front();
         checks++;
         assert (s.got === s.exp) else begin
            errors++;
            $display("ERROR at %0t: %s word %0d expected %h, actual %h", $time,
                     s.imem ? "imem_host_rdata" : "dmem_host_rdata", s.addr, s.exp, s.got);
         end
      end
   end

   initial begin
      reset     = 1'b1;
      enable    = 1'b0;
      imem_host = '0;
      dmem_host = '0;
      void'($urandom(63));
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      check_host_access();
      for (int which = 0; which < 4; which++) begin
         run_case(which, 1'b0);
      end
      // same programs again with random freezes
      run_case(1, 1'b1);
      run_case(2, 1'b1);
      run_case(3, 1'b1);
      repeat (2) @(posedge clk);
      @(negedge clk);
      $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0 && checks > 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
+incdir+sim
source/cpu_pkg.sv
source/sram.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu.sv
sim/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/sram.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/memory_stage.sv
      - source/cpu.sv
  - target: test
    include_dirs:
      - source
      - sim
    files:
      - sim/cpu_tb.sv
